// File: hdl/alu.sv
`timescale 1ns/1ps
`default_nettype none

// purely combinational, one op per cycle
module alu
(
	input  wire logic [backend_pkg::data_w-1:0] a,
	input  wire logic [backend_pkg::data_w-1:0] b,
	input  wire backend_pkg::alu_op_t           op,
	output logic      [backend_pkg::data_w-1:0] result,
	output logic                                zero
);

	logic [backend_pkg::data_w-1:0] sum;		// a + b
	logic [backend_pkg::data_w-1:0] diff;		// a - b
	logic                           lt_signed;	// a < b as signed
	logic [4:0]                     sh;		// shift distance

	assign sum  = a + b;
	assign diff = a - b;
	assign sh   = a[4:0];		// only low five bits count

	// sign compare without relying on diff overflow
	assign lt_signed = $signed(a) < $signed(b);

	////////////////////////////////////////
	// result mux
	////////////////////////////////////////

	always_comb
	begin
		result = '0;
		case (op)
			backend_pkg::alu_and: result = a & b;
			backend_pkg::alu_or:  result = a | b;
			backend_pkg::alu_add: result = sum;
			backend_pkg::alu_sub: result = diff;
			backend_pkg::alu_slt:
			begin
				// zero extended flag
				result = {{(backend_pkg::data_w-1){1'b0}}, lt_signed};
			end
			backend_pkg::alu_nor: result = ~(a | b);
			backend_pkg::alu_xor: result = a ^ b;
			backend_pkg::alu_sll: result = b << sh;
			backend_pkg::alu_srl: result = b >> sh;
			backend_pkg::alu_sra:
			begin
				result = $signed(b) >>> sh;		// keep sign bit
			end
			backend_pkg::alu_lui:
			begin
				result = {b[15:0], 16'h0000};		// imm into upper half
			end
			default: result = '0;		// unused codes
		endcase
	end

	// branch compare uses this after alu_sub
	assign zero = (result == '0);

endmodule

`default_nettype wire

// File: hdl/backend_pkg.sv
`default_nettype none

package backend_pkg;

	////////////////////////////////////////
	// widths
	////////////////////////////////////////

	localparam int data_w = 32;		// datapath and address width
	localparam int reg_w  = 5;		// register number, also shamt
	localparam int op_w   = 4;		// alu opcode

	// jal / jalr destination
	localparam logic [reg_w-1:0] link_reg = 5'd31;

	////////////////////////////////////////
	// data memory
	////////////////////////////////////////

	localparam int dmem_words = 64;		// word count
	localparam int dmem_aw    = 6;		// word address bits, byte addr [dmem_aw+1:2]

	////////////////////////////////////////
	// alu opcodes
	////////////////////////////////////////

	// encoding as decode drives it on in_alu_op
	typedef enum logic [op_w-1:0] {
		alu_and = 4'd0,
		alu_or  = 4'd1,
		alu_add = 4'd2,		// also address calc and link
		alu_sub = 4'd3,		// beq compare via zero flag
		alu_slt = 4'd4,		// signed
		alu_nor = 4'd5,
		alu_xor = 4'd6,
		alu_sll = 4'd7,		// b shifted by a[4:0]
		alu_srl = 4'd8,
		alu_sra = 4'd9,
		alu_lui = 4'd10		// b low half into upper half
	} alu_op_t;

	////////////////////////////////////////
	// operand sources
	////////////////////////////////////////

	typedef enum logic [1:0] {
		fwd_reg = 2'd0,		// value read in decode
		fwd_mem = 2'd1,		// alu result now in memory stage
		fwd_wb  = 2'd2		// final writeback value
	} fwd_sel_t;

endpackage

`default_nettype wire

// File: hdl/backend_top.sv
`timescale 1ns/1ps
`default_nettype none

module backend_top
(
	input  wire logic                          clk,
	input  wire logic                          arst_n,
	input  wire logic                          flush,
	input  wire logic                          in_valid,
	input  wire logic [backend_pkg::data_w-1:0] in_pc_plus4,
	input  wire logic [backend_pkg::data_w-1:0] in_reg1,
	input  wire logic [backend_pkg::data_w-1:0] in_reg2,
	input  wire logic [backend_pkg::data_w-1:0] in_imm,
	input  wire logic [backend_pkg::reg_w-1:0]  in_shamt,
	input  wire logic [backend_pkg::reg_w-1:0]  in_rs,
	input  wire logic [backend_pkg::reg_w-1:0]  in_rt,
	input  wire logic [backend_pkg::reg_w-1:0]  in_rd,
	input  wire backend_pkg::alu_op_t           in_alu_op,
	input  wire logic                          in_alu_src_imm,
	input  wire logic                          in_shift_shamt,
	input  wire logic                          in_link,
	input  wire logic                          in_reg_dst_rd,
	input  wire logic                          in_branch,
	input  wire logic                          in_mem_read,
	input  wire logic                          in_mem_write,
	input  wire logic                          in_reg_write,
	input  wire logic                          in_mem_to_reg,
	output logic                               branch_taken,
	output logic      [backend_pkg::data_w-1:0] branch_target,
	output logic                               wb_valid,		// register file write port
	output logic                               wb_reg_write,
	output logic      [backend_pkg::reg_w-1:0]  wb_reg,
	output logic      [backend_pkg::data_w-1:0] wb_data
);

	// ex/mem wires, also the mem forwarding source
	logic                           ex_valid;
	logic [backend_pkg::data_w-1:0] ex_alu;
	logic [backend_pkg::data_w-1:0] ex_reg2;
	logic [backend_pkg::reg_w-1:0]  ex_write_reg;
	logic                           ex_mem_read;
	logic                           ex_mem_write;
	logic                           ex_reg_write;
	logic                           ex_mem_to_reg;

	execute execute_i (
		.clk(clk), .arst_n(arst_n), .flush(flush),
		.in_valid(in_valid), .in_pc_plus4(in_pc_plus4),
		.in_reg1(in_reg1), .in_reg2(in_reg2), .in_imm(in_imm), .in_shamt(in_shamt),
		.in_rs(in_rs), .in_rt(in_rt), .in_rd(in_rd), .in_alu_op(in_alu_op),
		.in_alu_src_imm(in_alu_src_imm), .in_shift_shamt(in_shift_shamt),
		.in_link(in_link), .in_reg_dst_rd(in_reg_dst_rd), .in_branch(in_branch),
		.in_mem_read(in_mem_read), .in_mem_write(in_mem_write),
		.in_reg_write(in_reg_write), .in_mem_to_reg(in_mem_to_reg),
		// memory stage loops back as first forwarding source
		.mem_fwd_valid(ex_valid), .mem_fwd_reg_write(ex_reg_write),
		.mem_fwd_reg(ex_write_reg), .mem_fwd_data(ex_alu),
		// writeback port loops back as second
		.wb_fwd_valid(wb_valid), .wb_fwd_reg_write(wb_reg_write),
		.wb_fwd_reg(wb_reg), .wb_fwd_data(wb_data),
		.ex_valid(ex_valid), .ex_alu(ex_alu), .ex_reg2(ex_reg2),
		.ex_write_reg(ex_write_reg), .ex_mem_read(ex_mem_read),
		.ex_mem_write(ex_mem_write), .ex_reg_write(ex_reg_write),
		.ex_mem_to_reg(ex_mem_to_reg),
		.branch_taken(branch_taken), .branch_target(branch_target)
	);

	memory_stage memory_stage_i (
		.clk(clk), .arst_n(arst_n),
		.ex_valid(ex_valid), .ex_alu(ex_alu), .ex_reg2(ex_reg2),
		.ex_write_reg(ex_write_reg), .ex_mem_read(ex_mem_read),
		.ex_mem_write(ex_mem_write), .ex_reg_write(ex_reg_write),
		.ex_mem_to_reg(ex_mem_to_reg),
		.wb_valid(wb_valid), .wb_reg_write(wb_reg_write),
		.wb_reg(wb_reg), .wb_data(wb_data)
	);

endmodule

`default_nettype wire

// File: hdl/execute.sv
`timescale 1ns/1ps
`default_nettype none

module execute
(
	input  wire logic                          clk,
	input  wire logic                          arst_n,
	input  wire logic                          flush,		// kills the entering instr
	// decoded instruction
	input  wire logic                          in_valid,
	input  wire logic [backend_pkg::data_w-1:0] in_pc_plus4,
	input  wire logic [backend_pkg::data_w-1:0] in_reg1,
	input  wire logic [backend_pkg::data_w-1:0] in_reg2,
	input  wire logic [backend_pkg::data_w-1:0] in_imm,		// sign extended
	input  wire logic [backend_pkg::reg_w-1:0]  in_shamt,
	input  wire logic [backend_pkg::reg_w-1:0]  in_rs,
	input  wire logic [backend_pkg::reg_w-1:0]  in_rt,
	input  wire logic [backend_pkg::reg_w-1:0]  in_rd,
	input  wire backend_pkg::alu_op_t           in_alu_op,
	input  wire logic                          in_alu_src_imm,
	input  wire logic                          in_shift_shamt,
	input  wire logic                          in_link,
	input  wire logic                          in_reg_dst_rd,
	input  wire logic                          in_branch,
	input  wire logic                          in_mem_read,
	input  wire logic                          in_mem_write,
	input  wire logic                          in_reg_write,
	input  wire logic                          in_mem_to_reg,
	// forwarding sources
	input  wire logic                          mem_fwd_valid,
	input  wire logic                          mem_fwd_reg_write,
	input  wire logic [backend_pkg::reg_w-1:0]  mem_fwd_reg,
	input  wire logic [backend_pkg::data_w-1:0] mem_fwd_data,
	input  wire logic                          wb_fwd_valid,
	input  wire logic                          wb_fwd_reg_write,
	input  wire logic [backend_pkg::reg_w-1:0]  wb_fwd_reg,
	input  wire logic [backend_pkg::data_w-1:0] wb_fwd_data,
	// to memory stage
	output logic                               ex_valid,
	output logic      [backend_pkg::data_w-1:0] ex_alu,
	output logic      [backend_pkg::data_w-1:0] ex_reg2,		// store data
	output logic      [backend_pkg::reg_w-1:0]  ex_write_reg,
	output logic                               ex_mem_read,
	output logic                               ex_mem_write,
	output logic                               ex_reg_write,
	output logic                               ex_mem_to_reg,
	output logic                               branch_taken,
	output logic      [backend_pkg::data_w-1:0] branch_target
);

	backend_pkg::fwd_sel_t          sel_a;
	backend_pkg::fwd_sel_t          sel_b;
	logic [backend_pkg::data_w-1:0] fwd_a;		// repaired rs value
	logic [backend_pkg::data_w-1:0] fwd_b;		// repaired rt value
	logic [backend_pkg::data_w-1:0] op_a;
	logic [backend_pkg::data_w-1:0] op_b;
	logic [backend_pkg::data_w-1:0] alu_result;
	logic                           alu_zero;
	logic [backend_pkg::reg_w-1:0]  dest;
	logic [backend_pkg::data_w-1:0] target;
	logic                           live;		// instr survives into ex

	forwarding_unit forwarding_unit_i (
		.rs           (in_rs),
		.rt           (in_rt),
		.mem_valid    (mem_fwd_valid),
		.mem_reg_write(mem_fwd_reg_write),
		.mem_reg      (mem_fwd_reg),
		.wb_valid     (wb_fwd_valid),
		.wb_reg_write (wb_fwd_reg_write),
		.wb_reg       (wb_fwd_reg),
		.sel_a        (sel_a),
		.sel_b        (sel_b)
	);

	////////////////////////////////////////
	// forwarding muxes
	////////////////////////////////////////

	always_comb
	begin
		case (sel_a)
			backend_pkg::fwd_mem: fwd_a = mem_fwd_data;
			backend_pkg::fwd_wb:  fwd_a = wb_fwd_data;
			default:              fwd_a = in_reg1;
		endcase
		case (sel_b)
			backend_pkg::fwd_mem: fwd_b = mem_fwd_data;
			backend_pkg::fwd_wb:  fwd_b = wb_fwd_data;
			default:              fwd_b = in_reg2;
		endcase
	end

	// a: pc+4 for link, shamt for constant shifts
	always_comb
	begin
		if (in_link)
			op_a = in_pc_plus4;
		else if (in_shift_shamt)
			op_a = {{(backend_pkg::data_w-backend_pkg::reg_w){1'b0}}, in_shamt};
		else
			op_a = fwd_a;
	end

	// b: zero for link so add passes pc+4 through
	assign op_b = in_link ? '0 : (in_alu_src_imm ? in_imm : fwd_b);

	alu alu_i (
		.a     (op_a),
		.b     (op_b),
		.op    (in_alu_op),
		.result(alu_result),
		.zero  (alu_zero)
	);

	assign dest = in_link ? backend_pkg::link_reg : (in_reg_dst_rd ? in_rd : in_rt);
	assign target = in_pc_plus4 + {in_imm[backend_pkg::data_w-3:0], 2'b00};	// word offset
	assign live = in_valid && !flush;

	////////////////////////////////////////
	// ex/mem register
	////////////////////////////////////////

	// enables already qualified, later stages trust them
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			ex_valid      <= 1'b0;
			ex_mem_read   <= 1'b0;
			ex_mem_write  <= 1'b0;
			ex_reg_write  <= 1'b0;
			ex_mem_to_reg <= 1'b0;
			branch_taken  <= 1'b0;
		end
		else
		begin
			ex_valid      <= live;
			ex_mem_read   <= live && in_mem_read;
			ex_mem_write  <= live && in_mem_write;
			ex_reg_write  <= live && in_reg_write;
			ex_mem_to_reg <= in_mem_to_reg;
			branch_taken  <= live && in_branch && alu_zero;	// beq style
		end
	end

	always_ff @(posedge clk)
	begin
		ex_alu        <= alu_result;
		ex_reg2       <= fwd_b;		// forwarded, not stale
		ex_write_reg  <= dest;
		branch_target <= target;
	end

endmodule

`default_nettype wire

// File: hdl/forwarding_unit.sv
`timescale 1ns/1ps
`default_nettype none

// picks the source of each execute operand
// memory stage wins over writeback, r0 never forwarded
module forwarding_unit
(
	input  wire logic [backend_pkg::reg_w-1:0] rs,
	input  wire logic [backend_pkg::reg_w-1:0] rt,
	input  wire logic                          mem_valid,
	input  wire logic                          mem_reg_write,
	input  wire logic [backend_pkg::reg_w-1:0] mem_reg,
	input  wire logic                          wb_valid,
	input  wire logic                          wb_reg_write,
	input  wire logic [backend_pkg::reg_w-1:0] wb_reg,
	output backend_pkg::fwd_sel_t              sel_a,
	output backend_pkg::fwd_sel_t              sel_b
);

	logic mem_live;		// memory stage will write a real register
	logic wb_live;		// writeback will write a real register

	assign mem_live = mem_valid && mem_reg_write && (mem_reg != '0);
	assign wb_live  = wb_valid && wb_reg_write && (wb_reg != '0);

	// operand a, from rs
	always_comb
	begin
		if (mem_live && (mem_reg == rs))
			sel_a = backend_pkg::fwd_mem;		// youngest producer
		else if (wb_live && (wb_reg == rs))
			sel_a = backend_pkg::fwd_wb;
		else
			sel_a = backend_pkg::fwd_reg;
	end

	// operand b, from rt
	always_comb
	begin
		if (mem_live && (mem_reg == rt))
			sel_b = backend_pkg::fwd_mem;
		else if (wb_live && (wb_reg == rt))
			sel_b = backend_pkg::fwd_wb;
		else
			sel_b = backend_pkg::fwd_reg;
	end

endmodule

`default_nettype wire

// File: hdl/memory_stage.sv
`timescale 1ns/1ps
`default_nettype none

// data memory plus mem/wb register and final writeback mux
module memory_stage
(
	input  wire logic                          clk,
	input  wire logic                          arst_n,
	input  wire logic                          ex_valid,
	input  wire logic [backend_pkg::data_w-1:0] ex_alu,		// result or byte address
	input  wire logic [backend_pkg::data_w-1:0] ex_reg2,		// store data
	input  wire logic [backend_pkg::reg_w-1:0]  ex_write_reg,
	input  wire logic                          ex_mem_read,
	input  wire logic                          ex_mem_write,
	input  wire logic                          ex_reg_write,
	input  wire logic                          ex_mem_to_reg,
	output logic                               wb_valid,
	output logic                               wb_reg_write,
	output logic      [backend_pkg::reg_w-1:0]  wb_reg,
	output logic      [backend_pkg::data_w-1:0] wb_data
);

	logic [backend_pkg::data_w-1:0]  dmem [backend_pkg::dmem_words];
	logic [backend_pkg::dmem_aw-1:0] addr;		// word index
	logic [backend_pkg::data_w-1:0]  load_q;	// registered ram read
	logic [backend_pkg::data_w-1:0]  alu_q;		// registered alu result
	logic                            mem_to_reg_q;

	// word aligned, low two bits dropped
	assign addr = ex_alu[backend_pkg::dmem_aw+1:2];

	////////////////////////////////////////
	// data memory
	////////////////////////////////////////

	// sync ram, read and write share the edge
	always_ff @(posedge clk)
	begin
		if (ex_mem_write)
			dmem[addr] <= ex_reg2;		// valid already folded in
		if (ex_mem_read)
			load_q <= dmem[addr];		// old contents on same-address write
	end

	////////////////////////////////////////
	// mem/wb register
	////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			wb_valid     <= 1'b0;
			wb_reg_write <= 1'b0;
			mem_to_reg_q <= 1'b0;
		end
		else
		begin
			wb_valid     <= ex_valid;
			wb_reg_write <= ex_reg_write;	// low for stores
			mem_to_reg_q <= ex_mem_to_reg;
		end
	end

	always_ff @(posedge clk)
	begin
		alu_q  <= ex_alu;
		wb_reg <= ex_write_reg;
	end

	// writeback select, also the wb forwarding source
	assign wb_data = mem_to_reg_q ? load_q : alu_q;

endmodule

`default_nettype wire

// File: project.f
hdl/backend_pkg.sv
hdl/alu.sv
hdl/forwarding_unit.sv
hdl/execute.sv
hdl/memory_stage.sv
hdl/backend_top.sv
test/backend_properties.sv
test/backend_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the backend testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module backend_tb -f project.f \
	-o backend_sim > build.log 2>&1 \
	&& ./obj_dir/backend_sim > sim.log 2>&1 \
	|| { cat build.log sim.log 2>/dev/null; echo "build or simulation aborted"; exit 1; }

cat sim.log
grep -q "sim failed" sim.log && exit 1
grep -q "sim passed" sim.log || exit 1
exit 0

// File: test/backend_properties.sv
`timescale 1ns/1ps
`default_nettype none

// checks on the execute stage
module backend_properties
(
	input wire logic                           clk,
	input wire logic                           arst_n,
	input wire logic                           flush,
	input wire logic [backend_pkg::reg_w-1:0]  in_rs,
	input wire logic [backend_pkg::data_w-1:0] in_reg1,
	input wire logic [backend_pkg::data_w-1:0] fwd_a,
	input wire logic                           ex_valid,
	input wire logic [backend_pkg::data_w-1:0] ex_alu,
	input wire logic                           wb_fwd_valid,
	input wire logic                           branch_taken
);

	// killed instr leaves a bubble at writeback
	flush_kills: assert property (@(posedge clk) disable iff (!arst_n)
		$past(flush, 2) |-> !wb_fwd_valid)
		else $error("wb_valid high two cycles after flush");

	// r0 always takes the decode value
	r0_not_forwarded: assert property (@(posedge clk) disable iff (!arst_n)
		(in_rs == '0) |-> (fwd_a == in_reg1))
		else $error("rs zero took a forwarded value");

	taken_needs_valid: assert property (@(posedge clk) disable iff (!arst_n)
		branch_taken |-> (ex_valid && (ex_alu == '0)))
		else $error("branch_taken without a valid zero compare");

endmodule

bind execute backend_properties backend_properties_i (
	.clk(clk), .arst_n(arst_n), .flush(flush), .in_rs(in_rs), .in_reg1(in_reg1),
	.fwd_a(fwd_a), .ex_valid(ex_valid), .ex_alu(ex_alu), .wb_fwd_valid(wb_fwd_valid),
	.branch_taken(branch_taken)
);

`default_nettype wire

// File: test/backend_tb.sv
`timescale 1ns/1ps
`default_nettype none

module backend_tb;

	localparam int period        = 4;
	localparam int planned_instr = 50;		// issues plus idles over all tests
	localparam int margin        = 40;

	logic                           clk;
	logic                           arst_n;
	logic                           flush;
	logic                           in_valid;
	logic [backend_pkg::data_w-1:0] in_pc_plus4;
	logic [backend_pkg::data_w-1:0] in_reg1;
	logic [backend_pkg::data_w-1:0] in_reg2;
	logic [backend_pkg::data_w-1:0] in_imm;
	logic [backend_pkg::reg_w-1:0]  in_shamt;
	logic [backend_pkg::reg_w-1:0]  in_rs;
	logic [backend_pkg::reg_w-1:0]  in_rt;
	logic [backend_pkg::reg_w-1:0]  in_rd;
	backend_pkg::alu_op_t           in_alu_op;
	logic                           in_alu_src_imm;
	logic                           in_shift_shamt;
	logic                           in_link;
	logic                           in_reg_dst_rd;
	logic                           in_branch;
	logic                           in_mem_read;
	logic                           in_mem_write;
	logic                           in_reg_write;
	logic                           in_mem_to_reg;
	logic                           branch_taken;
	logic [backend_pkg::data_w-1:0] branch_target;
	logic                           wb_valid;
	logic                           wb_reg_write;
	logic [backend_pkg::reg_w-1:0]  wb_reg;
	logic [backend_pkg::data_w-1:0] wb_data;

	logic [backend_pkg::data_w-1:0] arch_rf [32];		// updated at issue
	logic [backend_pkg::data_w-1:0] stale_rf [32];		// what decode reads, updated at wb
	logic [backend_pkg::data_w-1:0] mem_model [backend_pkg::dmem_words];
	logic [backend_pkg::reg_w-1:0]  exp_reg_q [$];
	logic [backend_pkg::data_w-1:0] exp_data_q [$];
	logic [31:0]                    rng;
	logic [backend_pkg::data_w-1:0] pc;
	logic                           last_zero;		// model zero flag of last issue
	logic [backend_pkg::data_w-1:0] last_target;
	int                             err_count;
	int                             miss_count;
	int                             check_count;
	int                             i;

	backend_top backend_top_i (.*);

	initial
	begin
		clk = 1'b0;
		forever #(period/2) clk = ~clk;
	end

	// xorshift32
	function logic [31:0] next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	// reference alu, straight from the opcode rules
	function automatic logic [31:0] model_alu(backend_pkg::alu_op_t op, logic [31:0] a,
		logic [31:0] b);
		case (op)
			backend_pkg::alu_and: return a & b;
			backend_pkg::alu_or:  return a | b;
			backend_pkg::alu_add: return a + b;
			backend_pkg::alu_sub: return a - b;
			backend_pkg::alu_slt: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			backend_pkg::alu_nor: return ~(a | b);
			backend_pkg::alu_xor: return a ^ b;
			backend_pkg::alu_sll: return b << a[4:0];
			backend_pkg::alu_srl: return b >> a[4:0];
			backend_pkg::alu_sra: return $unsigned($signed(b) >>> a[4:0]);
			backend_pkg::alu_lui: return {b[15:0], 16'h0000};
			default:              return 32'd0;
		endcase
	endfunction

	////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////

	task automatic check_wb(input logic [backend_pkg::reg_w-1:0] got_reg,
		input logic [backend_pkg::reg_w-1:0] exp_reg,
		input logic [backend_pkg::data_w-1:0] got_data,
		input logic [backend_pkg::data_w-1:0] exp_data);
		check_count++;
		if (got_reg !== exp_reg || got_data !== exp_data)
		begin
			err_count++;
			$display("ERR %0t writeback r%0d=%h, expected r%0d=%h", $time,
				got_reg, got_data, exp_reg, exp_data);
		end
	endtask

	task automatic check_branch(input logic got_taken, input logic exp_taken,
		input logic [backend_pkg::data_w-1:0] got_target,
		input logic [backend_pkg::data_w-1:0] exp_target);
		check_count++;
		if (got_taken !== exp_taken || got_target !== exp_target)
		begin
			err_count++;
			$display("ERR %0t branch taken=%b target=%h, expected taken=%b target=%h",
				$time, got_taken, got_target, exp_taken, exp_target);
		end
	endtask

	task automatic check_valid(input logic got_valid, input logic exp_valid);
		check_count++;
		if (got_valid !== exp_valid)
		begin
			err_count++;
			$display("ERR %0t wb_valid=%b, expected %b", $time, got_valid, exp_valid);
		end
	endtask

	////////////////////////////////////////
	// stimulus
	////////////////////////////////////////

	// one decoded instr, model updated in program order
	task automatic issue(input backend_pkg::alu_op_t op,
		input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] rd,
		input logic [31:0] imm, input logic [4:0] shamt,
		input logic src_imm, input logic shift_shamt, input logic link,
		input logic reg_dst_rd, input logic branch, input logic mem_read,
		input logic mem_write, input logic reg_write, input logic kill);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] res;
		logic [31:0] val;
		logic [4:0]  dest;
		logic [backend_pkg::dmem_aw-1:0] idx;
		@(posedge clk);
		in_valid       <= 1'b1;
		flush          <= kill;
		in_pc_plus4    <= pc + 32'd4;
		in_reg1        <= stale_rf[rs];		// forwarding repairs these
		in_reg2        <= stale_rf[rt];
		in_imm         <= imm;
		in_shamt       <= shamt;
		in_rs          <= rs;
		in_rt          <= rt;
		in_rd          <= rd;
		in_alu_op      <= op;
		in_alu_src_imm <= src_imm;
		in_shift_shamt <= shift_shamt;
		in_link        <= link;
		in_reg_dst_rd  <= reg_dst_rd;
		in_branch      <= branch;
		in_mem_read    <= mem_read;
		in_mem_write   <= mem_write;
		in_reg_write   <= reg_write;
		in_mem_to_reg  <= mem_read;
		a = link ? pc + 32'd4 : (shift_shamt ? {27'd0, shamt} : arch_rf[rs]);
		b = link ? 32'd0 : (src_imm ? imm : arch_rf[rt]);
		res = model_alu(op, a, b);
		dest = link ? backend_pkg::link_reg : (reg_dst_rd ? rd : rt);
		idx = res[backend_pkg::dmem_aw+1:2];
		last_zero = (res == 32'd0);
		last_target = pc + 32'd4 + imm * 32'd4;
		pc = pc + 32'd4;
		if (!kill)
		begin
			if (mem_write)
				mem_model[idx] = arch_rf[rt];
			if (reg_write)
			begin
				val = mem_read ? mem_model[idx] : res;
				exp_reg_q.push_back(dest);
				exp_data_q.push_back(val);
				if (dest != 5'd0)
					arch_rf[dest] = val;		// r0 stays zero
			end
		end
	endtask

	task automatic idle();
		@(posedge clk);
		in_valid <= 1'b0;
		flush    <= 1'b0;
	endtask

	task automatic rr(input backend_pkg::alu_op_t op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] rd);
		issue(op, rs, rt, rd, 32'd0, 5'd0, 1'b0, 1'b0, 1'b0, 1'b1,
			1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
	endtask

	// rd set to r9 so a wrong dest select shows up
	task automatic imm_op(input backend_pkg::alu_op_t op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [31:0] imm);
		issue(op, rs, rt, 5'd9, imm, 5'd0, 1'b1, 1'b0, 1'b0, 1'b0,
			1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
	endtask

	task automatic beq(input logic [4:0] rs, input logic [4:0] rt, input logic [31:0] imm);
		issue(backend_pkg::alu_sub, rs, rt, 5'd0, imm, 5'd0, 1'b0, 1'b0, 1'b0, 1'b0,
			1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
		idle();
		@(negedge clk);
		check_branch(branch_taken, last_zero, branch_target, last_target);
	endtask

	////////////////////////////////////////
	// tests
	////////////////////////////////////////

	// sources r1..r8, dests r16..r23, nothing depends
	task automatic test_alu_rr();
		logic [31:0] r;
		repeat (12)
		begin
			r = next_rand();
			rr(backend_pkg::alu_op_t'(r[3:0] % 4'd10), {2'b00, r[6:4]} + 5'd1,
				{2'b00, r[9:7]} + 5'd1, {2'b10, r[12:10]});
		end
	endtask

	task automatic test_imm_shift();
		imm_op(backend_pkg::alu_add, 5'd1, 5'd24, 32'hffff_fff0);		// negative imm
		imm_op(backend_pkg::alu_lui, 5'd0, 5'd25, 32'h0000_beef);
		imm_op(backend_pkg::alu_or, 5'd4, 5'd28, 32'h0000_00ff);
		issue(backend_pkg::alu_sll, 5'd0, 5'd2, 5'd26, 32'd0, 5'd7, 1'b0, 1'b1, 1'b0, 1'b1,
			1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
		issue(backend_pkg::alu_sra, 5'd0, 5'd3, 5'd27, 32'd0, 5'd31, 1'b0, 1'b1, 1'b0, 1'b1,
			1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
	endtask

	task automatic test_forwarding();
		imm_op(backend_pkg::alu_add, 5'd0, 5'd10, 32'd100);
		rr(backend_pkg::alu_add, 5'd10, 5'd10, 5'd11);		// mem fwd both sides
		rr(backend_pkg::alu_sub, 5'd10, 5'd11, 5'd12);		// wb on a, mem on b
		imm_op(backend_pkg::alu_add, 5'd0, 5'd13, 32'd7);
		imm_op(backend_pkg::alu_add, 5'd0, 5'd13, 32'd9);
		rr(backend_pkg::alu_or, 5'd13, 5'd0, 5'd14);		// both match, mem wins
		imm_op(backend_pkg::alu_add, 5'd0, 5'd0, 32'd55);		// write to r0
		rr(backend_pkg::alu_add, 5'd0, 5'd0, 5'd15);
	endtask

	task automatic test_load_store();
		logic [31:0] v;
		v = next_rand();
		imm_op(backend_pkg::alu_lui, 5'd0, 5'd16, {16'd0, v[31:16]});
		imm_op(backend_pkg::alu_or, 5'd16, 5'd16, {16'd0, v[15:0]});
		// sw r16 -> 0x20, data arrives by forwarding
		issue(backend_pkg::alu_add, 5'd0, 5'd16, 5'd0, 32'h20, 5'd0, 1'b1, 1'b0, 1'b0, 1'b0,
			1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
		issue(backend_pkg::alu_add, 5'd0, 5'd1, 5'd0, 32'h3c, 5'd0, 1'b1, 1'b0, 1'b0, 1'b0,
			1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
		rr(backend_pkg::alu_and, 5'd1, 5'd2, 5'd18);
		issue(backend_pkg::alu_add, 5'd0, 5'd17, 5'd0, 32'h20, 5'd0, 1'b1, 1'b0, 1'b0, 1'b0,
			1'b0, 1'b1, 1'b0, 1'b1, 1'b0);
		issue(backend_pkg::alu_add, 5'd0, 5'd19, 5'd0, 32'h3c, 5'd0, 1'b1, 1'b0, 1'b0, 1'b0,
			1'b0, 1'b1, 1'b0, 1'b1, 1'b0);
	endtask

	task automatic test_branch_flush();
		imm_op(backend_pkg::alu_add, 5'd0, 5'd20, 32'd33);
		imm_op(backend_pkg::alu_add, 5'd0, 5'd21, 32'd33);
		imm_op(backend_pkg::alu_add, 5'd0, 5'd22, 32'd34);
		repeat (3) idle();
		beq(5'd20, 5'd21, 32'd5);		// taken
		beq(5'd20, 5'd22, 32'hffff_fffd);		// not taken, backward offset
		// killed in execute, must never reach writeback
		issue(backend_pkg::alu_add, 5'd0, 5'd23, 5'd0, 32'd77, 5'd0, 1'b1, 1'b0, 1'b0, 1'b0,
			1'b0, 1'b0, 1'b0, 1'b1, 1'b1);
		idle();
		idle();
		@(negedge clk);
		check_valid(wb_valid, 1'b0);		// bubble now at writeback
	endtask

	task automatic test_link();
		issue(backend_pkg::alu_add, 5'd0, 5'd0, 5'd0, 32'd0, 5'd0, 1'b0, 1'b0, 1'b1, 1'b0,
			1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
	endtask

	// writeback port acts as the register file write
	always @(negedge clk)
	begin
		if (arst_n && wb_valid && wb_reg_write)
		begin
			if (exp_reg_q.size() == 0)
			begin
				miss_count++;
				$display("unexpected writeback to r%0d at %0t", wb_reg, $time);
			end
			else
			begin
				check_wb(wb_reg, exp_reg_q[0], wb_data, exp_data_q[0]);
				if (exp_reg_q[0] != 5'd0)
					stale_rf[exp_reg_q[0]] = exp_data_q[0];
				void'(exp_reg_q.pop_front());
				void'(exp_data_q.pop_front());
			end
		end
	end

	initial
	begin
		repeat (planned_instr + margin) @(posedge clk);
		$display("watchdog expired before the tests finished");
		$display("sim failed");
		$finish;
	end

	initial
	begin
		rng = 32'd48;
		pc = 32'h0000_1000;
		err_count = 0;
		miss_count = 0;
		check_count = 0;
		arst_n = 1'b0;
		flush = 1'b0;
		in_valid = 1'b0;
		in_pc_plus4 = '0;
		in_reg1 = '0;
		in_reg2 = '0;
		in_imm = '0;
		in_shamt = '0;
		in_rs = '0;
		in_rt = '0;
		in_rd = '0;
		in_alu_op = backend_pkg::alu_and;
		in_alu_src_imm = 1'b0;
		in_shift_shamt = 1'b0;
		in_link = 1'b0;
		in_reg_dst_rd = 1'b0;
		in_branch = 1'b0;
		in_mem_read = 1'b0;
		in_mem_write = 1'b0;
		in_reg_write = 1'b0;
		in_mem_to_reg = 1'b0;
		for (i = 0; i < 32; i++)
		begin
			arch_rf[i] = (i == 0) ? 32'd0 : next_rand();
			stale_rf[i] = arch_rf[i];
		end
		repeat (3) @(posedge clk);
		arst_n <= 1'b1;
		test_alu_rr();
		test_imm_shift();
		test_forwarding();
		test_load_store();
		test_branch_flush();
		test_link();
		repeat (4) idle();		// drain both stages
		@(negedge clk);
		if (exp_reg_q.size() != 0)
		begin
			miss_count += exp_reg_q.size();
			$display("%0d expected writebacks never appeared", exp_reg_q.size());
		end
		$display("checks %0d, errors %0d, missing %0d", check_count, err_count, miss_count);
		if (err_count == 0 && miss_count == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire
